/* src/hisPkg.sv */
package hisPkg;

    // default geometry of the histogram builder
    // the top level passes these down as module parameters
    parameter int binW = 4;
    parameter int fineShift = 2;
    // a code is one coarse bin index plus the fine bits below it
    parameter int dataW = binW + fineShift;
    parameter int countW = 8;
    parameter int pixW = 2;

    // samples per pixel, acquisitions per pass
    parameter int sampleNum = 3;
    parameter int acqNum = 2;

    // pass sequence, one way only until reset
    typedef enum logic [1:0] {
        coarsePass,
        settle,
        finePass,
        done
    } passState;

    // raw sample code
    typedef logic [dataW-1:0] code_t;
    // histogram bin index
    typedef logic [binW-1:0] bin_t;
    // hits in one bin
    typedef logic [countW-1:0] count_t;
    // pixel index
    typedef logic [pixW-1:0] pixel_t;

endpackage

/* src/hisIfs.sv */
`timescale 1ns/1ns

// per-sample control from the sequencer
interface hisStepIf;
    // accepted sample, one cycle
    logic step;
    // pixel the current sample belongs to
    hisPkg::pixel_t pixel;
    // level, high for the whole fine pass
    logic fine;
    // pass change, drops all valid bits and peak maxima
    logic clear;
    // start of the window base load
    logic loadWin;

    modport driver (
        output step,
        output pixel,
        output fine,
        output clear,
        output loadWin
    );

    modport sink (
        input step,
        input pixel,
        input fine,
        input clear,
        input loadWin
    );
endinterface

// registered bin update, memory to peak tracker
interface hisUpdateIf;
    logic upd;
    hisPkg::pixel_t pixel;
    hisPkg::bin_t bin;
    // count after the increment
    hisPkg::count_t count;

    modport driver (output upd, output pixel, output bin, output count);
    modport sink (input upd, input pixel, input bin, input count);
endinterface

/* src/hisSequencer.sv */
`timescale 1ns/1ns

module hisSequencer #(
    parameter int sampleNum = hisPkg::sampleNum,
    parameter int pixW = hisPkg::pixW,
    parameter int acqNum = hisPkg::acqNum
) (
    input logic clk,
    input logic combin_res,
    input logic wrEn,
    output logic ready,
    output logic done,
    hisStepIf.driver stepIf
);

    localparam int pixNum = 1 << pixW;
    localparam int sampleCntW = $clog2(sampleNum + 1);
    localparam int acqCntW = $clog2(acqNum + 1);
    // settle cycles between the passes
    localparam int settleLen = 3;

    hisPkg::passState state;
    logic [sampleCntW-1:0] sampleCnt;
    hisPkg::pixel_t pixelCnt;
    logic [acqCntW-1:0] acqCnt;
    logic [1:0] settleCnt;

    logic sampleLast;
    logic pixelLast;
    logic acqLast;
    logic passLast;

    // counter carries
    assign sampleLast = sampleCnt == sampleCntW'(sampleNum - 1);
    assign pixelLast = pixelCnt == pixW'(pixNum - 1);
    assign acqLast = acqCnt == acqCntW'(acqNum - 1);
    // last sample of the last pixel of the last acquisition
    assign passLast = sampleLast && pixelLast && acqLast;

    // only the two counting passes take samples
    assign ready = (state == hisPkg::coarsePass) || (state == hisPkg::finePass);
    assign done = state == hisPkg::done;

    assign stepIf.step = wrEn && ready;
    assign stepIf.pixel = pixelCnt;
    assign stepIf.fine = state == hisPkg::finePass;
    // coarse peaks are final by the second settle cycle
    assign stepIf.loadWin = (state == hisPkg::settle) && (settleCnt == 2'd1);
    assign stepIf.clear = (state == hisPkg::settle) && (settleCnt == 2'd2);

    // sample, pixel and acquisition each wrap on their own carry
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else if (stepIf.step) begin
            if (!sampleLast) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                pixelCnt <= pixelCnt + 1'b1;
                if (pixelLast) begin
                    acqCnt <= acqLast ? '0 : acqCnt + 1'b1;
                end
            end
        end
    end

    // pass FSM
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= hisPkg::coarsePass;
            settleCnt <= '0;
        end else begin
            case (state)
                hisPkg::coarsePass: begin
                    if (stepIf.step && passLast) begin
                        state <= hisPkg::settle;
                    end
                end
                hisPkg::settle: begin
                    if (settleCnt == 2'(settleLen - 1)) begin
                        settleCnt <= '0;
                        state <= hisPkg::finePass;
                    end else begin
                        settleCnt <= settleCnt + 1'b1;
                    end
                end
                hisPkg::finePass: begin
                    if (stepIf.step && passLast) begin
                        state <= hisPkg::done;
                    end
                end
                // done holds until reset
                default: state <= state;
            endcase
        end
    end

    // fine pass starts again from the first sample of pixel 0
    countersWrapAtSettle: assert property (@(posedge clk) disable iff (!combin_res)
        state == hisPkg::settle |-> sampleCnt == '0 && pixelCnt == '0 && acqCnt == '0);

endmodule

/* src/hisBinMapper.sv */
`timescale 1ns/1ns

module hisBinMapper #(
    parameter int binW = hisPkg::binW,
    parameter int fineShift = hisPkg::fineShift,
    parameter int pixW = hisPkg::pixW
) (
    input logic clk,
    input logic combin_res,
    input hisPkg::code_t data,
    hisStepIf.sink stepIf,
    input hisPkg::pixel_t peakPixel,
    // tracker peak bin at selPixel
    input hisPkg::bin_t winPeak,
    output hisPkg::bin_t bin,
    output hisPkg::code_t windowBase,
    output hisPkg::pixel_t selPixel
);

    localparam int dataW = binW + fineShift;
    localparam int binNum = 1 << binW;
    localparam int pixNum = 1 << pixW;
    // highest base that still keeps the window inside the code range
    localparam int baseMax = (1 << dataW) - binNum;
    localparam int halfCoarse = (1 << fineShift) / 2;

    hisPkg::code_t winBase [pixNum];
    logic loading;
    hisPkg::pixel_t loadIdx;
    logic signed [dataW+1:0] rawBase;
    hisPkg::code_t newBase;
    hisPkg::code_t pixBase;
    hisPkg::code_t offset;

    // load index drives the tracker select, else the readout pixel
    assign selPixel = (stepIf.loadWin || loading) ? loadIdx : peakPixel;
    assign windowBase = winBase[peakPixel];

    // centre the window on the middle of the coarse peak bin
    always_comb begin
        rawBase = ((dataW + 2)'(winPeak) << fineShift) + (dataW + 2)'(halfCoarse)
            - (dataW + 2)'(binNum / 2);
        if (rawBase < 0) begin
            newBase = '0;
        end else if (rawBase > baseMax) begin
            newBase = dataW'(baseMax);
        end else begin
            newBase = dataW'(rawBase);
        end
    end

    // code to bin
    always_comb begin
        pixBase = winBase[stepIf.pixel];
        offset = data - pixBase;
        if (!stepIf.fine) begin
            bin = binW'(data >> fineShift);
        end else if (data < pixBase) begin
            // below the window
            bin = '0;
        end else if (offset >= dataW'(binNum)) begin
            // past the window
            bin = '1;
        end else begin
            bin = binW'(offset);
        end
    end

    // one pixel per cycle, starting with pixel 0 on the loadWin pulse
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            loading <= 1'b0;
            loadIdx <= '0;
            for (int p = 0; p < pixNum; p++) begin
                winBase[p] <= '0;
            end
        end else if (stepIf.loadWin || loading) begin
            winBase[loadIdx] <= newBase;
            loadIdx <= loadIdx + 1'b1;
            // index wraps back to 0 after the last pixel
            loading <= loadIdx != pixW'(pixNum - 1);
        end
    end

    // fine samples only reach pixels whose base is already loaded
    baseLoadedFirst: assert property (@(posedge clk) disable iff (!combin_res)
        loading && stepIf.step |-> stepIf.pixel < loadIdx);

endmodule

/* src/hisBinMemory.sv */
`timescale 1ns/1ns

module hisBinMemory #(
    parameter int binW = hisPkg::binW,
    parameter int countW = hisPkg::countW,
    parameter int pixW = hisPkg::pixW
) (
    input logic clk,
    input logic combin_res,
    hisStepIf.sink stepIf,
    input hisPkg::bin_t bin,
    hisUpdateIf.driver updIf,
    output hisPkg::count_t binCount,
    output logic binCountValid
);

    localparam int depth = 1 << (pixW + binW);

    // counts with one row of bins per pixel
    hisPkg::count_t mem [depth];
    // entry holds a count of this pass
    logic [depth-1:0] valid;
    logic [pixW+binW-1:0] addr;
    hisPkg::count_t nextCount;
    hisPkg::pixel_t updPixel;
    hisPkg::bin_t updBin;

    assign addr = {stepIf.pixel, bin};
    // a stale entry counts as empty
    assign nextCount = valid[addr] ? mem[addr] + countW'(1) : countW'(1);

    always_ff @(posedge clk) begin
        if (stepIf.step) begin
            mem[addr] <= nextCount;
        end
    end

    // flash clear at the pass change
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid <= '0;
        end else if (stepIf.clear) begin
            valid <= '0;
        end else if (stepIf.step) begin
            valid[addr] <= 1'b1;
        end
    end

    // update strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binCountValid <= 1'b0;
        end else begin
            binCountValid <= stepIf.step;
        end
    end

    // new count with its position one cycle after the sample
    always_ff @(posedge clk) begin
        if (stepIf.step) begin
            binCount <= nextCount;
            updPixel <= stepIf.pixel;
            updBin <= bin;
        end
    end

    assign updIf.upd = binCountValid;
    assign updIf.count = binCount;
    assign updIf.pixel = updPixel;
    assign updIf.bin = updBin;

    // a bin count must not wrap within one pass
    noCountWrap: assert property (@(posedge clk) disable iff (!combin_res)
        stepIf.step && valid[addr] |-> mem[addr] != '1);

endmodule

/* src/hisPeakTracker.sv */
`timescale 1ns/1ns

module hisPeakTracker #(
    parameter int pixW = hisPkg::pixW
) (
    input logic clk,
    input logic combin_res,
    hisUpdateIf.sink updIf,
    // clear only
    hisStepIf.sink stepIf,
    input hisPkg::pixel_t peakPixel,
    output hisPkg::bin_t peakBin,
    output hisPkg::count_t peakCount
);

    localparam int pixNum = 1 << pixW;

    // running maximum per pixel
    hisPkg::count_t maxCount [pixNum];
    // bin that first reached that maximum
    hisPkg::bin_t maxBin [pixNum];
    logic isHigher;

    // strictly greater, so ties keep the earlier bin
    assign isHigher = updIf.count > maxCount[updIf.pixel];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixNum; p++) begin
                maxCount[p] <= '0;
            end
        end else if (stepIf.clear) begin
            // restart tracking for the new pass
            for (int p = 0; p < pixNum; p++) begin
                maxCount[p] <= '0;
            end
        end else if (updIf.upd && isHigher) begin
            maxCount[updIf.pixel] <= updIf.count;
        end
    end

    // bins survive the clear
    // the window load still reads them while the fine pass starts
    // first fine hit of a pixel beats the zeroed maximum and replaces it
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixNum; p++) begin
                maxBin[p] <= '0;
            end
        end else if (updIf.upd && isHigher && !stepIf.clear) begin
            maxBin[updIf.pixel] <= updIf.bin;
        end
    end

    // readout, also feeds the window base load
    assign peakBin = maxBin[peakPixel];
    assign peakCount = maxCount[peakPixel];

endmodule

/* src/hisBuilderTop.sv */
`timescale 1ns/1ns

module hisBuilderTop #(
    parameter int binW = hisPkg::binW,
    parameter int fineShift = hisPkg::fineShift,
    parameter int countW = hisPkg::countW,
    parameter int pixW = hisPkg::pixW,
    parameter int sampleNum = hisPkg::sampleNum,
    parameter int acqNum = hisPkg::acqNum
) (
    input logic clk,
    input logic combin_res,
    input logic wrEn,
    input hisPkg::code_t data,
    input hisPkg::pixel_t peakPixel,
    output hisPkg::count_t binCount,
    output logic binCountValid,
    output logic fine,
    output logic ready,
    output logic done,
    output hisPkg::bin_t peakBin,
    output hisPkg::count_t peakCount,
    output hisPkg::code_t windowBase
);

    hisStepIf stepIf ();
    hisUpdateIf updIf ();

    // mapped bin of the current sample
    hisPkg::bin_t bin;
    // tracker select, load index or readout pixel
    hisPkg::pixel_t selPixel;

    assign fine = stepIf.fine;

    hisSequencer #(
        .sampleNum(sampleNum),
        .pixW(pixW),
        .acqNum(acqNum)
    ) sequencer_i (
        .clk(clk),
        .combin_res(combin_res),
        .wrEn(wrEn),
        .ready(ready),
        .done(done),
        .stepIf(stepIf.driver)
    );

    hisBinMapper #(
        .binW(binW),
        .fineShift(fineShift),
        .pixW(pixW)
    ) binMapper_i (
        .clk(clk),
        .combin_res(combin_res),
        .data(data),
        .stepIf(stepIf.sink),
        .peakPixel(peakPixel),
        .winPeak(peakBin),
        .bin(bin),
        .windowBase(windowBase),
        .selPixel(selPixel)
    );

    hisBinMemory #(
        .binW(binW),
        .countW(countW),
        .pixW(pixW)
    ) binMemory_i (
        .clk(clk),
        .combin_res(combin_res),
        .stepIf(stepIf.sink),
        .bin(bin),
        .updIf(updIf.driver),
        .binCount(binCount),
        .binCountValid(binCountValid)
    );

    hisPeakTracker #(
        .pixW(pixW)
    ) peakTracker_i (
        .clk(clk),
        .combin_res(combin_res),
        .updIf(updIf.sink),
        .stepIf(stepIf.sink),
        .peakPixel(selPixel),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

endmodule

/* test/hisBuilderChecks.svh */
task automatic checkCount(input hisPkg::count_t got, input hisPkg::count_t exp,
    input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic checkBin(input hisPkg::bin_t got, input hisPkg::bin_t exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic checkCode(input hisPkg::code_t got, input hisPkg::code_t exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic checkFlag(input logic got, input bit exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// 8 bit Galois LFSR for x^8 + x^6 + x^5 + x^4 + 1
bit [7:0] lfsrState = 8'd53;

// one LFSR step per returned bit
function automatic logic [31:0] nextBits(input int width);
    logic [31:0] val;
    bit outBit;
    val = '0;
    for (int i = 0; i < width; i++) begin
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 8'hB8;
        end
        val = {val[30:0], outBit};
    end
    return val;
endfunction

/* test/hisBuilderTb.sv */
`timescale 1ns/1ns

module hisBuilderTb;

    localparam int pixNum = 1 << hisPkg::pixW;
    localparam int binNum = 1 << hisPkg::binW;
    localparam int passLen = hisPkg::sampleNum * pixNum * hisPkg::acqNum;
    // highest window base that keeps the window inside the code range
    localparam int baseLimit = (1 << hisPkg::dataW) - binNum;
    localparam int maxWait = 50;

    logic clk;
    logic combin_res;
    logic wrEn;
    hisPkg::code_t data;
    hisPkg::pixel_t peakPixel;
    hisPkg::count_t binCount;
    logic binCountValid;
    logic fine;
    logic ready;
    logic done;
    hisPkg::bin_t peakBin;
    hisPkg::count_t peakCount;
    hisPkg::code_t windowBase;

    int errors;
    int checks;
    int timeouts;

    // reference model state
    hisPkg::count_t modelCount [pixNum][binNum];
    bit modelValid [pixNum][binNum];
    hisPkg::count_t modelPeakCount [pixNum];
    hisPkg::bin_t modelPeakBin [pixNum];
    hisPkg::code_t modelBase [pixNum];

    `include "hisBuilderChecks.svh"

    hisBuilderTop #(
        .binW(hisPkg::binW),
        .fineShift(hisPkg::fineShift),
        .countW(hisPkg::countW),
        .pixW(hisPkg::pixW),
        .sampleNum(hisPkg::sampleNum),
        .acqNum(hisPkg::acqNum)
    ) dut_i (
        .clk(clk),
        .combin_res(combin_res),
        .wrEn(wrEn),
        .data(data),
        .peakPixel(peakPixel),
        .binCount(binCount),
        .binCountValid(binCountValid),
        .fine(fine),
        .ready(ready),
        .done(done),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .windowBase(windowBase)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void modelReset();
        for (int p = 0; p < pixNum; p++) begin
            modelPeakCount[p] = '0;
            modelPeakBin[p] = '0;
            modelBase[p] = '0;
            for (int b = 0; b < binNum; b++) begin
                modelCount[p][b] = '0;
                modelValid[p][b] = 1'b0;
            end
        end
    endfunction

    // coarse pass drops the fine bits
    // fine pass takes the offset into the pixel window clamped at both ends
    function automatic hisPkg::bin_t modelBin(input hisPkg::code_t code, input int pix,
        input bit inFine);
        int offset;
        if (!inFine) begin
            return hisPkg::bin_t'(code >> hisPkg::fineShift);
        end
        offset = int'(code) - int'(modelBase[pix]);
        if (offset < 0) begin
            return '0;
        end
        if (offset >= binNum) begin
            return hisPkg::bin_t'(binNum - 1);
        end
        return hisPkg::bin_t'(offset);
    endfunction

    // count one sample and return the count the DUT should report
    function automatic hisPkg::count_t modelAccept(input hisPkg::code_t code, input int pix,
        input bit inFine);
        hisPkg::bin_t b;
        b = modelBin(code, pix, inFine);
        if (modelValid[pix][b]) begin
            modelCount[pix][b] = hisPkg::count_t'(modelCount[pix][b] + 1);
        end else begin
            modelCount[pix][b] = hisPkg::count_t'(1);
            modelValid[pix][b] = 1'b1;
        end
        // first bin to reach a new maximum wins
        if (modelCount[pix][b] > modelPeakCount[pix]) begin
            modelPeakCount[pix] = modelCount[pix][b];
            modelPeakBin[pix] = b;
        end
        return modelCount[pix][b];
    endfunction

    // window bases from the coarse peaks and then drop all counts
    function automatic void modelPassChange();
        int raw;
        for (int p = 0; p < pixNum; p++) begin
            raw = int'(modelPeakBin[p]) * (1 << hisPkg::fineShift)
                + (1 << hisPkg::fineShift) / 2 - binNum / 2;
            if (raw < 0) begin
                raw = 0;
            end
            if (raw > baseLimit) begin
                raw = baseLimit;
            end
            modelBase[p] = hisPkg::code_t'(raw);
            modelPeakCount[p] = '0;
            for (int b = 0; b < binNum; b++) begin
                modelValid[p][b] = 1'b0;
            end
        end
    endfunction

    // pixel 0 sits near code 0 and the last pixel near the code maximum
    // the pixels between take LFSR codes
    // fine codes 40 and 63 of pixel 0 both lie past its window
    function automatic hisPkg::code_t pickCode(input bit inFine, input int pix, input int s);
        if (pix == 0) begin
            if (!inFine) begin
                return hisPkg::code_t'((s == 2) ? 3 : 1);
            end
            return hisPkg::code_t'((s == 0) ? 0 : ((s == 1) ? 40 : 63));
        end
        if (pix == pixNum - 1) begin
            if (!inFine) begin
                return hisPkg::code_t'(62);
            end
            return hisPkg::code_t'((s == 0) ? 10 : ((s == 1) ? 50 : 63));
        end
        return hisPkg::code_t'(nextBits(hisPkg::dataW));
    endfunction

    task automatic waitReady();
        int n;
        n = 0;
        while (!ready && n < maxWait) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ready) begin
            timeouts++;
            $display("timeout: ready stayed low for %0d cycles", maxWait);
        end
    endtask

    task automatic waitDone();
        int n;
        n = 0;
        while (!done && n < maxWait) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!done) begin
            timeouts++;
            $display("timeout: done stayed low for %0d cycles", maxWait);
        end
    endtask

    // one sample through the DUT with its count checked against the model
    task automatic sendSample(input hisPkg::code_t code, input int pix, input bit inFine,
        input bit lastOfPass, output hisPkg::count_t seen);
        hisPkg::count_t exp;
        int lat;
        waitReady();
        exp = modelAccept(code, pix, inFine);
        wrEn = 1'b1;
        data = code;
        @(posedge clk);
        #2;
        wrEn = 1'b0;
        if (lastOfPass) begin
            checkFlag(ready, 1'b0, "ready after last sample of pass");
        end
        lat = 1;
        while (!binCountValid && lat < maxWait) begin
            @(posedge clk);
            #2;
            lat++;
        end
        seen = binCount;
        if (!binCountValid) begin
            timeouts++;
            $display("timeout: no binCountValid for a sample after %0d cycles", maxWait);
        end else begin
            checkFlag(lat == 1, 1'b1, "binCountValid one cycle after accept");
            checkCount(binCount, exp, "binCount");
        end
        @(posedge clk);
        #2;
        checkFlag(binCountValid, 1'b0, "binCountValid single pulse");
    endtask

    task automatic testReset();
        checkFlag(ready, 1'b1, "ready after reset");
        checkFlag(done, 1'b0, "done after reset");
        checkFlag(fine, 1'b0, "fine after reset");
        checkFlag(binCountValid, 1'b0, "binCountValid after reset");
    endtask

    // full pass in the pixel order of the sequencer counters
    task automatic runPass(input bit inFine);
        hisPkg::count_t seen;
        int pix;
        for (int i = 0; i < passLen; i++) begin
            pix = (i / hisPkg::sampleNum) % pixNum;
            checkFlag(fine, inFine, "fine level during pass");
            sendSample(pickCode(inFine, pix, i % hisPkg::sampleNum), pix, inFine,
                i == passLen - 1, seen);
            // bin 0 of pixel 0 ended the coarse pass well above 1
            if (inFine && i == 0) begin
                checkCount(seen, hisPkg::count_t'(1), "first fine hit after clear");
            end
        end
    endtask

    task automatic testPassChange();
        int n;
        checkFlag(ready, 1'b0, "ready in settle");
        // strobes during settle must be dropped
        n = 0;
        while (!ready && n < maxWait) begin
            checkFlag(binCountValid, 1'b0, "binCountValid during settle");
            wrEn = 1'b1;
            @(posedge clk);
            #2;
            n++;
        end
        wrEn = 1'b0;
        if (!ready) begin
            timeouts++;
            $display("timeout: fine pass never became ready");
        end
        checkFlag(fine, 1'b1, "fine together with ready");
        checkFlag(binCountValid, 1'b0, "binCountValid at fine start");
        modelPassChange();
        // window load walks one pixel per cycle into the fine pass
        repeat (pixNum) @(posedge clk);
        #2;
        for (int p = 0; p < pixNum; p++) begin
            peakPixel = hisPkg::pixel_t'(p);
            #1;
            checkCode(windowBase, modelBase[p], "windowBase");
            // both clamps of the base rule
            if (p == 0) begin
                checkCode(windowBase, '0, "windowBase low clamp");
            end
            if (p == pixNum - 1) begin
                checkCode(windowBase, hisPkg::code_t'(baseLimit), "windowBase high clamp");
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic testDone();
        waitDone();
        checkFlag(ready, 1'b0, "ready when done");
        for (int p = 0; p < pixNum; p++) begin
            peakPixel = hisPkg::pixel_t'(p);
            #1;
            checkBin(peakBin, modelPeakBin[p], "peakBin");
            checkCount(peakCount, modelPeakCount[p], "peakCount");
        end
        @(posedge clk);
        #2;
        // no more samples taken
        for (int k = 0; k < 4; k++) begin
            wrEn = 1'b1;
            @(posedge clk);
            #2;
            checkFlag(binCountValid, 1'b0, "binCountValid after done");
            checkFlag(done, 1'b1, "done holds");
        end
        wrEn = 1'b0;
    endtask

    initial begin
        errors = 0;
        checks = 0;
        timeouts = 0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        peakPixel = '0;
        modelReset();
        repeat (5) @(posedge clk);
        #2;
        combin_res = 1'b1;
        testReset();
        runPass(1'b0);
        testPassChange();
        runPass(1'b1);
        testDone();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+test
src/hisPkg.sv
src/hisIfs.sv
src/hisSequencer.sv
src/hisBinMapper.sv
src/hisBinMemory.sv
src/hisPeakTracker.sv
src/hisBuilderTop.sv
test/hisBuilderTb.sv

/* run.sh */
#!/bin/sh
# build and run the histogram builder testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module hisBuilderTb -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** TEST PASSED ***" sim.log; then
    exit 0
fi
exit 1
